// ==== design/video_pkg.sv ====
//----------------------------------------
// Video package
// Colour index, channel and palette types
// shared by VGA timing and the drawer
//----------------------------------------
package video_pkg;

    typedef logic [3:0] color_idx_t;            // Tile colour index
    typedef logic [7:0] rgb_t;                  // One 8-bit colour channel

    localparam int NUM_COLORS = 16;             // Entries in the palette

    //----------------------------------------
    // Palette, {red, green, blue} per index
    //----------------------------------------
    localparam logic [23:0] PALETTE [NUM_COLORS] = '{
        24'h000000,                             // Black, background
        24'h0000aa,                             // Blue
        24'h00aa00,                             // Green
        24'h00aaaa,                             // Cyan
        24'haa0000,                             // Red
        24'haa00aa,                             // Magenta
        24'haa5500,                             // Brown
        24'haaaaaa,                             // Light grey
        24'h555555,                             // Dark grey
        24'h5555ff,                             // Bright blue
        24'h55ff55,                             // Bright green
        24'h55ffff,                             // Bright cyan
        24'hff5555,                             // Bright red
        24'hff55ff,                             // Bright magenta
        24'hffff55,                             // Yellow
        24'hffffff                              // White
    };

endpackage

// ==== design/blit_pkg.sv ====
//----------------------------------------
// Blitter package
// Opcodes, FSM states and tile coordinates
//----------------------------------------
package blit_pkg;

    // Keycode word layout
    //   [15:12] opcode
    //   [11:8]  colour index
    //   [7:4]   tile column x
    //   [3:0]   tile row y

    typedef logic [3:0] tile_coord_t;           // Tile column or row, 0..15

    // Drawing opcodes, other codes are illegal
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,                        // Nothing
        OP_PLOT  = 4'd1,                        // One tile at (x, y)
        OP_ROW   = 4'd2,                        // All 16 tiles of row y
        OP_COL   = 4'd3,                        // All 16 tiles of column x
        OP_CLEAR = 4'd4                         // Whole 16 x 16 grid
    } blit_op_e;

    typedef enum logic [1:0] {
        BLIT_IDLE,                              // No command in progress
        BLIT_WAIT_VBLANK,                       // Holding until vertical blank
        BLIT_WRITE                              // One tile per cycle
    } blit_state_e;

endpackage

// ==== design/keycode_decoder.sv ====
//----------------------------------------
// Keycode decoder
// Splits a strobed keycode into a blit
// command and keeps one pending slot
//----------------------------------------
`timescale 1ns/1ps

module keycode_decoder
    import video_pkg::*;
    import blit_pkg::*;
(
    input  logic        Clk,
    input  logic        arst_n,
    input  logic [15:0] keycode,
    input  logic        keycode_strobe,
    input  logic        cmd_take,
    output logic        cmd_valid,
    output blit_op_e    cmd_op,
    output color_idx_t  cmd_color,
    output tile_coord_t cmd_x,
    output tile_coord_t cmd_y
);

    blit_op_e kc_op;                            // Opcode field
    logic     kc_legal;                         // Opcode does real drawing
    logic     accept;                           // Load pending slot

    assign kc_op = blit_op_e'(keycode[15:12]);

    always_comb begin
        case (kc_op)
            OP_PLOT, OP_ROW, OP_COL, OP_CLEAR: kc_legal = 1'b1;
            default:                           kc_legal = 1'b0; // NOP and illegal
        endcase
    end

    // Strobes while a command waits are lost
    assign accept = keycode_strobe && kc_legal && !cmd_valid;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_valid <= 1'b0;
        end else if (cmd_take) begin
            cmd_valid <= 1'b0;                  // Blitter has the command
        end else if (accept) begin
            cmd_valid <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            cmd_op    <= kc_op;
            cmd_color <= keycode[11:8];
            cmd_x     <= keycode[7:4];
            cmd_y     <= keycode[3:0];
        end
    end

endmodule

// ==== design/blitter.sv ====
//----------------------------------------
// Tile blitter
// Runs one command as a burst of tile
// writes, only inside vertical blanking
//----------------------------------------
`timescale 1ns/1ps

module blitter
    import video_pkg::*;
    import blit_pkg::*;
(
    input  logic        Clk,
    input  logic        arst_n,
    input  logic        cmd_valid,
    input  blit_op_e    cmd_op,
    input  color_idx_t  cmd_color,
    input  tile_coord_t cmd_x,
    input  tile_coord_t cmd_y,
    input  logic        vblank,
    output logic        cmd_take,
    output logic        busy,
    output logic        wr_en,
    output logic [7:0]  wr_addr,
    output color_idx_t  wr_color
);

    blit_state_e state;
    blit_op_e    op_q;                          // Latched command
    color_idx_t  color_q;
    tile_coord_t x_q;
    tile_coord_t y_q;
    logic [7:0]  cnt;                           // Tiles written so far
    logic [7:0]  last_cnt;                      // Final count for the shape

    //----------------------------------------
    // Shape walk, address is {row, column}
    //----------------------------------------
    always_comb begin
        case (op_q)
            OP_ROW: begin
                wr_addr  = {y_q, cnt[3:0]};     // Sweep columns of row y
                last_cnt = 8'd15;
            end
            OP_COL: begin
                wr_addr  = {cnt[3:0], x_q};     // Sweep rows of column x
                last_cnt = 8'd15;
            end
            OP_CLEAR: begin
                wr_addr  = cnt;                 // Whole grid in raster order
                last_cnt = 8'd255;
            end
            default: begin
                wr_addr  = {y_q, x_q};          // Single plot
                last_cnt = 8'd0;
            end
        endcase
    end

    assign wr_en    = (state == BLIT_WRITE) && vblank; // Held off outside vblank
    assign wr_color = color_q;
    assign busy     = cmd_take || (state != BLIT_IDLE);

    //----------------------------------------
    // Control FSM
    //----------------------------------------
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= BLIT_IDLE;
            cmd_take <= 1'b0;
            cnt      <= '0;
        end else begin
            cmd_take <= 1'b0;                   // Single-cycle pulse
            case (state)
                BLIT_IDLE: begin
                    if (cmd_take) begin
                        state <= BLIT_WAIT_VBLANK;
                        cnt   <= '0;
                    end else if (cmd_valid) begin
                        cmd_take <= 1'b1;       // One cycle after valid
                    end
                end
                BLIT_WAIT_VBLANK: begin
                    if (vblank) state <= BLIT_WRITE;
                end
                BLIT_WRITE: begin
                    if (!vblank) begin
                        state <= BLIT_WAIT_VBLANK; // Pause, resume next blank
                    end else if (cnt == last_cnt) begin
                        state <= BLIT_IDLE;     // Last tile written
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                default: state <= BLIT_IDLE;
            endcase
        end
    end

    // Command copy taken with the pulse
    always_ff @(posedge Clk) begin
        if ((state == BLIT_IDLE) && cmd_take) begin
            op_q    <= cmd_op;
            color_q <= cmd_color;
            x_q     <= cmd_x;
            y_q     <= cmd_y;
        end
    end

endmodule

// ==== design/frame_buffer.sv ====
//----------------------------------------
// Frame buffer
// 256 x 4-bit tile colour RAM, one write
// port and one registered read port
//----------------------------------------
`timescale 1ns/1ps

module frame_buffer
    import video_pkg::*;
(
    input  logic       Clk,
    input  logic       wr_en,
    input  logic [7:0] wr_addr,
    input  color_idx_t wr_color,
    input  logic [7:0] rd_addr,
    output color_idx_t rd_color
);

    color_idx_t mem [256];                      // One entry per tile

    // Write port, blitter side
    always_ff @(posedge Clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_color;
        end
    end

    // Read port, drawer side, one cycle latency
    always_ff @(posedge Clk) begin
        rd_color <= mem[rd_addr];
    end

endmodule

// ==== design/vga_timing.sv ====
//----------------------------------------
// VGA timing generator
// Line and frame counters with sync,
// active and vertical blank levels
//----------------------------------------
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic       Clk,
    input  logic       arst_n,
    output logic       hs,
    output logic       vs,
    output logic       active,
    output logic       vblank,
    output logic [9:0] draw_x,
    output logic [9:0] draw_y
);

    localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START  = H_ACTIVE + H_FRONT;  // First sync pixel
    localparam int VS_START  = V_ACTIVE + V_FRONT;  // First sync line

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       line_end;

    assign line_end = (h_cnt == 10'(H_TOTAL - 1));

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            if (v_cnt == 10'(V_TOTAL - 1)) begin
                v_cnt <= '0;                    // Wrap to top of frame
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // Syncs are active low
    assign hs = !((h_cnt >= HS_START) && (h_cnt < HS_START + H_SYNC));
    assign vs = !((v_cnt >= VS_START) && (v_cnt < VS_START + V_SYNC));

    assign active = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    assign vblank = (v_cnt >= V_ACTIVE);        // Whole line outside picture
    assign draw_x = h_cnt;
    assign draw_y = v_cnt;

endmodule

// ==== design/frame_drawer.sv ====
//----------------------------------------
// Frame drawer
// Fetches the tile under the beam, maps
// it through the palette, delays syncs
//----------------------------------------
`timescale 1ns/1ps

module frame_drawer
    import video_pkg::*;
#(
    parameter int TILE_SHIFT = 5
) (
    input  logic       Clk,
    input  logic       arst_n,
    input  logic [9:0] draw_x,
    input  logic [9:0] draw_y,
    input  logic       active,
    input  logic       hs,
    input  logic       vs,
    output logic [7:0] rd_addr,
    input  color_idx_t rd_color,
    output rgb_t       vga_r,
    output rgb_t       vga_g,
    output rgb_t       vga_b,
    output logic       vga_hs,
    output logic       vga_vs,
    output logic       vga_blank_n
);

    localparam int GRID_PIX = 16 << TILE_SHIFT; // Grid edge in pixels

    logic       in_grid;
    logic       hs_d, vs_d, active_d, in_grid_d; // Stage 1, matches RAM read
    color_idx_t pix_idx;
    logic [23:0] pix_rgb;

    assign in_grid = (draw_x < GRID_PIX) && (draw_y < GRID_PIX);
    assign rd_addr = {draw_y[TILE_SHIFT +: 4], draw_x[TILE_SHIFT +: 4]}; // Row, column

    assign pix_idx = in_grid_d ? rd_color : '0;  // Border shows index 0
    assign pix_rgb = PALETTE[pix_idx];

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            hs_d        <= 1'b1;
            vs_d        <= 1'b1;
            active_d    <= 1'b0;
            in_grid_d   <= 1'b0;
            vga_hs      <= 1'b1;
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
        end else begin
            hs_d        <= hs;
            vs_d        <= vs;
            active_d    <= active;
            in_grid_d   <= in_grid;
            vga_hs      <= hs_d;                 // Stage 2, port register
            vga_vs      <= vs_d;
            vga_blank_n <= active_d;
            vga_r       <= active_d ? pix_rgb[23:16] : '0; // Black while blanked
            vga_g       <= active_d ? pix_rgb[15:8]  : '0;
            vga_b       <= active_d ? pix_rgb[7:0]   : '0;
        end
    end

endmodule

// ==== design/tile_display_top.sv ====
//----------------------------------------
// Tile display top
// Keycode in, tiles drawn, VGA out
//----------------------------------------
`timescale 1ns/1ps

module tile_display_top
    import video_pkg::*;
    import blit_pkg::*;
#(
    parameter int H_ACTIVE   = 640,
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_ACTIVE   = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int TILE_SHIFT = 5
) (
    input  logic        Clk,
    input  logic        arst_n,
    input  logic [15:0] keycode,
    input  logic        keycode_strobe,
    output rgb_t        vga_r,
    output rgb_t        vga_g,
    output rgb_t        vga_b,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n,
    output logic        busy
);

    // Decoder to blitter
    logic        cmd_valid, cmd_take;
    blit_op_e    cmd_op;
    color_idx_t  cmd_color;
    tile_coord_t cmd_x, cmd_y;

    // Frame buffer ports
    logic        wr_en;
    logic [7:0]  wr_addr, rd_addr;
    color_idx_t  wr_color, rd_color;

    // Beam position and levels
    logic        hs, vs, active, vblank;
    logic [9:0]  draw_x, draw_y;

    keycode_decoder u_decoder (.*);             // Decode

    blitter u_blitter (.*);                     // Execute

    frame_buffer u_fb (.*);

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (.*);

    frame_drawer #(
        .TILE_SHIFT(TILE_SHIFT)
    ) u_drawer (.*);                            // Result, RGB and syncs

endmodule

// ==== tb/tb_tile_display.sv ====
//----------------------------------------
// Tile display testbench
// Directed keycode tests, grid model and
// a scanout checker on the VGA ports
//----------------------------------------
`timescale 1ns/1ps

module tb_tile_display
    import video_pkg::*;
    import blit_pkg::*;
;

    localparam int H_ACTIVE = 64, H_FRONT = 2, H_SYNC = 4, H_BACK = 2;
    localparam int V_ACTIVE = 64, V_FRONT = 2, V_SYNC = 4, V_BACK = 2;
    localparam int TILE_SHIFT = 2;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES; // Tests need about 5 frames

    logic        Clk = 1'b0;
    logic        arst_n, keycode_strobe, busy;
    logic [15:0] keycode;
    rgb_t        vga_r, vga_g, vga_b;
    logic        vga_hs, vga_vs, vga_blank_n;

    logic [3:0]  model [16][16];                // Expected grid indexed [row][column]
    integer      seed = 41;
    int          errors = 0, checks = 0, cyc = 0;
    bit          timed_out = 1'b0;
    // Scanout monitor state
    int          px = 0, py = 0, checked = 0, vs_falls = 0;
    int          hs_fall = 0, vs_fall = 0, line_len, hs_width, frame_len, vs_width;
    int          hs_rise = 0, vs_rise = 0, h_back, v_back;
    int          active_w, active_h;
    bit          hs_q = 1'b1, vs_q = 1'b1, blank_q = 1'b0;
    bit          arm = 1'b0, checking = 1'b0, port_vblank = 1'b0;

    tile_display_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .TILE_SHIFT(TILE_SHIFT)
    ) u_dut (.*);

    always #10 Clk = ~Clk;                      // 20 ns period

    //----------------------------------------
    // Helpers
    //----------------------------------------
    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    function automatic logic [3:0] rnd4();
        return 4'($random(seed));
    endfunction

    // Grid update by opcode rules
    function automatic void apply_cmd(logic [3:0] op, logic [3:0] c, logic [3:0] x, logic [3:0] y);
        int i, j;
        for (i = 0; i < 16; i++) begin
            for (j = 0; j < 16; j++) begin
                if ((op == OP_CLEAR) || (op == OP_ROW && i == y) ||
                    (op == OP_COL && j == x) || (op == OP_PLOT && i == y && j == x)) begin
                    model[i][j] = c;
                end
            end
        end
    endfunction

    function automatic logic [23:0] expected_rgb(int x, int y);
        int col, row;
        col = x >> TILE_SHIFT;
        row = y >> TILE_SHIFT;
        if (col > 15 || row > 15) return PALETTE[0]; // Outside the grid
        return PALETTE[model[row][col]];
    endfunction

    task automatic drive_key(logic [3:0] op, logic [3:0] c, logic [3:0] x, logic [3:0] y);
        @(posedge Clk);
        keycode        <= {op, c, x, y};
        keycode_strobe <= 1'b1;
    endtask

    task automatic end_keys();
        @(posedge Clk);
        keycode_strobe <= 1'b0;
    endtask

    task automatic send_key(logic [3:0] op, logic [3:0] c, logic [3:0] x, logic [3:0] y);
        drive_key(op, c, x, y);
        end_keys();
    endtask

    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin                 // Covers the gap between queued commands
            @(negedge Clk);
            quiet = busy ? 0 : quiet + 1;
        end
    endtask

    task automatic check_frame();
        arm = 1'b1;                             // Starts at next top-left pixel
        wait (!arm && !checking);
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    //----------------------------------------
    // Scanout monitor sampled mid-cycle
    //----------------------------------------
    always @(negedge Clk) begin
        cyc++;
        if (hs_q && !vga_hs) begin
            line_len = cyc - hs_fall;
            hs_fall  = cyc;
        end
        if (!hs_q && vga_hs) begin
            hs_width = cyc - hs_fall;
            hs_rise  = cyc;
        end
        if (vs_q && !vga_vs) begin
            frame_len = cyc - vs_fall;
            vs_fall   = cyc;
            active_h  = py;                     // Lines seen this frame
            vs_falls++;
        end
        if (!vs_q && vga_vs) begin
            vs_width = cyc - vs_fall;
            vs_rise  = cyc;
        end
        if (!vga_vs) py = 0;
        if (vga_blank_n) begin
            if (!blank_q) begin                 // Start of an active line
                port_vblank = 1'b0;
                h_back      = cyc - hs_rise;
                if (py == 0) v_back = cyc - vs_rise;
            end
            if (arm && px == 0 && py == 0) begin
                arm      = 1'b0;
                checking = 1'b1;
                checked  = 0;
            end
            if (checking) begin
                check_value("vga_rgb", expected_rgb(px, py), {vga_r, vga_g, vga_b});
                checked++;
            end
            px++;
        end else begin
            if (blank_q) begin                  // End of an active line
                active_w = px;
                px = 0;
                py++;
                if (py == V_ACTIVE) port_vblank = 1'b1;
            end
            if (checking) check_value("vga_rgb blanked", 0, {vga_r, vga_g, vga_b});
        end
        if (checked == H_ACTIVE * V_ACTIVE) checking = 1'b0;
        hs_q    = vga_hs;
        vs_q    = vga_vs;
        blank_q = vga_blank_n;
    end

    //----------------------------------------
    // Directed tests
    //----------------------------------------
    task automatic reset_values();
        @(negedge Clk);
        check_value("busy", 0, busy);
        check_value("vga_hs", 1, vga_hs);
        check_value("vga_vs", 1, vga_vs);
        check_value("vga_blank_n", 0, vga_blank_n);
        check_value("vga_rgb", 0, {vga_r, vga_g, vga_b});
    endtask

    task automatic sync_timing();
        wait (vs_falls >= 2);                   // Full frame and vsync seen
        check_value("line length", H_TOTAL, line_len);
        check_value("hsync width", H_SYNC, hs_width);
        check_value("frame length", FRAME_CYCLES, frame_len);
        check_value("vsync width", V_SYNC * H_TOTAL, vs_width);
        check_value("active width", H_ACTIVE, active_w);
        check_value("active height", V_ACTIVE, active_h);
        check_value("hsync to active", H_BACK, h_back);
        check_value("vsync to active", V_BACK * H_TOTAL, v_back);
    endtask

    task automatic clear_screen();
        logic [3:0] c;
        c = rnd4();
        send_key(OP_CLEAR, c, rnd4(), rnd4());
        while (!busy) @(negedge Clk);
        while (busy) @(negedge Clk);
        check_value("vblank at busy fall", 1, port_vblank);
        wait_idle();
        apply_cmd(OP_CLEAR, c, 0, 0);
        check_frame();
    endtask

    task automatic draw_shapes();
        logic [3:0] c, x, y;
        for (int k = 1; k <= 3; k++) begin      // Plot then row then column
            c = rnd4();
            x = rnd4();
            y = rnd4();
            send_key(k[3:0], c, x, y);
            wait_idle();
            apply_cmd(k[3:0], c, x, y);
        end
        check_frame();
    endtask

    task automatic drop_and_queue();
        logic [3:0] c1, x1, y1, c2, x2, y2;
        send_key(OP_NOP, rnd4(), rnd4(), rnd4());
        send_key(4'ha, rnd4(), rnd4(), rnd4()); // Illegal opcode
        repeat (4) begin
            @(negedge Clk);
            check_value("busy", 0, busy);
        end
        c1 = rnd4();
        x1 = rnd4();
        y1 = rnd4();
        c2 = rnd4();
        x2 = rnd4();
        y2 = rnd4();
        send_key(OP_PLOT, c1, x1, y1);
        while (!busy) @(negedge Clk);
        drive_key(OP_ROW, c2, x2, y2);          // Held pending
        drive_key(OP_COL, rnd4(), rnd4(), rnd4()); // Dropped while the slot is full
        end_keys();
        wait_idle();
        apply_cmd(OP_PLOT, c1, x1, y1);
        apply_cmd(OP_ROW, c2, x2, y2);
        check_frame();
    endtask

    initial begin
        arst_n         = 1'b0;
        keycode        = '0;
        keycode_strobe = 1'b0;
        repeat (10) @(posedge Clk);
        arst_n <= 1'b1;
        reset_values();
        sync_timing();
        clear_screen();
        draw_shapes();
        drop_and_queue();
        finish_run();
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        timed_out = 1'b1;
        finish_run();
    end

endmodule

// ==== tile_display.f ====
design/video_pkg.sv
design/blit_pkg.sv
design/keycode_decoder.sv
design/blitter.sv
design/frame_buffer.sv
design/vga_timing.sv
design/frame_drawer.sv
design/tile_display_top.sv
tb/tb_tile_display.sv

// ==== Bender.yml ====
package:
  name: tile_display

sources:
  # Packages first, then the design in dependency order
  - design/video_pkg.sv
  - design/blit_pkg.sv
  - design/keycode_decoder.sv
  - design/blitter.sv
  - design/frame_buffer.sv
  - design/vga_timing.sv
  - design/frame_drawer.sv
  - design/tile_display_top.sv

  # Testbench, top module tb_tile_display
  - target: test
    files:
      - tb/tb_tile_display.sv
